/* issue_stage.f */
verilog/isa_pkg.sv
verilog/issue_pkg.sv
verilog/issue_decoder.sv
verilog/issue_cu.sv
verilog/issue_reg.sv
verilog/issue_stage.sv
tb/tb_issue_stage.sv

/* tb/tb_issue_stage.sv */
// Issue stage testbench
`timescale 1ns/1ps
`default_nettype none

module tb_issue_stage;

    logic clk_i, rst_n_i, flush_i;
    logic iq_valid_i, iq_ready_o, iq_except_raised_i;
    isa_pkg::instr_t iq_instr_i, ex_instr_o, comm_instr_o;
    isa_pkg::except_code_t iq_except_code_i, comm_except_code_o;
    logic rs1_ready_i, ex_ready_i, ex_valid_o, int_regstat_valid_o;
    isa_pkg::xlen_t rs1_value_i, comm_res_value_o;
    isa_pkg::reg_addr_t int_regstat_rd_o;
    logic comm_ready_i, comm_valid_o, comm_res_ready_o, comm_jb_instr_o;
    logic comm_except_o, comm_resume_i;

    isa_pkg::instr_t        exp_instr [$];   // accepted and waiting for commit
    issue_pkg::issue_type_t exp_cls [$];
    isa_pkg::except_code_t  exp_code [$];
    isa_pkg::xlen_t         exp_res [$];
    isa_pkg::instr_t        table_w [16];
    int                     value_errs = 0;
    int                     proto_errs = 0;
    logic                   rand_ready = 1'b0;
    logic [31:0]            ins_seed = 32'h6fbf_1b67;

    issue_stage u_issue_stage (.*);

    initial begin : clock_gen
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // --------------------------------------------------
    // expected class, code and result of a word
    // --------------------------------------------------
    function automatic void ref_decode(input isa_pkg::instr_t w, input logic fe,
                                       input isa_pkg::except_code_t fcode,
                                       input isa_pkg::xlen_t rs1v,
                                       output issue_pkg::issue_type_t cls,
                                       output isa_pkg::except_code_t code,
                                       output isa_pkg::xlen_t res);
        isa_pkg::opcode_t op;
        op   = w[6:0];
        cls  = issue_pkg::ISSUE_TYPE_EXCEPT;
        code = isa_pkg::EXC_ILLEGAL;
        res  = {w[31:12], 12'h000};       // U-immediate
        if (fe) code = fcode;
        else if (op == isa_pkg::OPCODE_OP || op == isa_pkg::OPCODE_OP_IMM
              || op == isa_pkg::OPCODE_AUIPC || op == isa_pkg::OPCODE_LOAD)
            cls = issue_pkg::ISSUE_TYPE_INT;
        else if (op == isa_pkg::OPCODE_LUI) cls = issue_pkg::ISSUE_TYPE_LUI;
        else if (op == isa_pkg::OPCODE_STORE) cls = issue_pkg::ISSUE_TYPE_STORE;
        else if (op == isa_pkg::OPCODE_BRANCH) cls = issue_pkg::ISSUE_TYPE_BRANCH;
        else if (op == isa_pkg::OPCODE_JAL || op == isa_pkg::OPCODE_JALR)
            cls = issue_pkg::ISSUE_TYPE_JUMP;
        else if (op == isa_pkg::OPCODE_OP_FP) cls = issue_pkg::ISSUE_TYPE_FP;
        else if (op == isa_pkg::OPCODE_MISC_MEM) cls = issue_pkg::ISSUE_TYPE_STALL;
        else if (op == isa_pkg::OPCODE_SYSTEM) begin
            if (w[14:12] != 3'b000) begin
                cls = issue_pkg::ISSUE_TYPE_CSR;
                res = rs1v;                 // csr read hands back rs1
            end else if (w == 32'h1050_0073) cls = issue_pkg::ISSUE_TYPE_WFI;
            else if (w == 32'h0000_0073) code = isa_pkg::EXC_ECALL;
            else if (w == 32'h0010_0073) code = isa_pkg::EXC_BREAKPOINT;
        end
    endfunction

    // --------------------------------------------------
    // compare tasks
    // --------------------------------------------------
    task automatic check_instr(input string name, input isa_pkg::instr_t e, a);
        if (e !== a) begin
            value_errs++;
            $display("Fail %s: expected %h, actual %h", name, e, a);
        end
    endtask

    task automatic check_xlen(input string name, input isa_pkg::xlen_t e, a);
        if (e !== a) begin
            value_errs++;
            $display("Fail %s: expected %h, actual %h", name, e, a);
        end
    endtask

    task automatic check_code(input string name, input isa_pkg::except_code_t e, a);
        if (e !== a) begin
            value_errs++;
            $display("Fail %s: expected %0d, actual %0d", name, e, a);
        end
    endtask

    task automatic check_rd(input string name, input isa_pkg::reg_addr_t e, a);
        if (e !== a) begin
            value_errs++;
            $display("Fail %s: expected %0d, actual %0d", name, e, a);
        end
    endtask

    task automatic check_bit(input string name, input logic e, a);
        if (e !== a) begin
            value_errs++;
            $display("Fail %s: expected %b, actual %b", name, e, a);
        end
    endtask

    // ready inputs are random or held high
    initial begin : ready_driver
        logic [31:0] s;
        s = lcg_next(32'h6fbf_1b67);
        forever begin
            @(posedge clk_i);
            #2;
            s = lcg_next(s);
            ex_ready_i   = rand_ready ? (s[20] | s[21]) : 1'b1;
            comm_ready_i = rand_ready ? (s[22] | s[23]) : 1'b1;
        end
    end

    // --------------------------------------------------
    // downstream monitor
    // --------------------------------------------------
    always @(posedge clk_i) begin : commit_monitor
        issue_pkg::issue_type_t c;
        isa_pkg::instr_t        w;
        isa_pkg::except_code_t  code;
        isa_pkg::xlen_t         res;
        logic ex_cls, jb_cls, res_cls, rs_cls;
        if (rst_n_i && ex_valid_o && !(ex_ready_i && comm_ready_i)) begin
            proto_errs++;
            $display("ex_valid_o is high while a ready input is low");
        end
        if (rst_n_i && comm_valid_o && comm_ready_i) begin
            if (exp_instr.size() == 0) begin
                proto_errs++;
                $display("commit transfer with no accepted instruction pending");
            end else begin
                w    = exp_instr.pop_front();
                c    = exp_cls.pop_front();
                code = exp_code.pop_front();
                res  = exp_res.pop_front();
                jb_cls  = (c == issue_pkg::ISSUE_TYPE_BRANCH)
                       || (c == issue_pkg::ISSUE_TYPE_JUMP);
                ex_cls  = jb_cls || (c == issue_pkg::ISSUE_TYPE_INT)
                       || (c == issue_pkg::ISSUE_TYPE_STORE)
                       || (c == issue_pkg::ISSUE_TYPE_FP);
                res_cls = (c == issue_pkg::ISSUE_TYPE_LUI)
                       || (c == issue_pkg::ISSUE_TYPE_CSR);
                rs_cls  = res_cls || (c == issue_pkg::ISSUE_TYPE_INT)
                       || (c == issue_pkg::ISSUE_TYPE_JUMP);
                check_instr("commit instr", w, comm_instr_o);
                check_bit("commit except", c == issue_pkg::ISSUE_TYPE_EXCEPT, comm_except_o);
                if (c == issue_pkg::ISSUE_TYPE_EXCEPT)
                    check_code("except code", code, comm_except_code_o);
                check_bit("ex_valid", ex_cls, ex_valid_o);
                if (ex_cls) check_instr("ex instr", w, ex_instr_o);
                check_bit("jb instr", jb_cls, comm_jb_instr_o);
                check_bit("regstat valid", rs_cls, int_regstat_valid_o);
                if (rs_cls) check_rd("regstat rd", w[11:7], int_regstat_rd_o);
                check_bit("res ready", res_cls, comm_res_ready_o);
                if (res_cls) check_xlen("res value", res, comm_res_value_o);
            end
        end
    end

    task automatic wait_iq_ready();
        int n;
        n = 0;
        while (!iq_ready_o && n < 50) begin
            @(posedge clk_i);
            #2;
            n++;
        end
        if (!iq_ready_o) begin
            proto_errs++;
            $display("iq_ready_o did not rise within 50 cycles");
        end
    endtask

    task automatic wait_commit_drain();
        int n;
        n = 0;
        while (exp_instr.size() != 0 && n < 500) begin
            @(posedge clk_i);
            #2;
            n++;
        end
        if (exp_instr.size() != 0) begin
            proto_errs++;
            $display("accepted instructions never reached commit");
        end
    endtask

    // hold after CSR, exceptions, fences and WFI until resume or flush
    task automatic release_stall(input issue_pkg::issue_type_t cls, input logic use_flush);
        if (cls == issue_pkg::ISSUE_TYPE_CSR) begin
            repeat (3) begin
                @(posedge clk_i);
                check_bit("csr waits for rs1", 1'b0, comm_valid_o);
            end
            #2 rs1_ready_i = 1'b1;
        end
        wait_commit_drain();
        repeat (3) begin
            @(posedge clk_i);
            check_bit("stalled iq_ready", 1'b0, iq_ready_o);
        end
        #2;
        if (use_flush) flush_i = 1'b1;
        else comm_resume_i = 1'b1;
        @(posedge clk_i);
        #2;
        flush_i       = 1'b0;
        comm_resume_i = 1'b0;
        wait_iq_ready();
    endtask

    task automatic send_instr(input isa_pkg::instr_t w, input logic fe,
                              input isa_pkg::except_code_t fcode, input logic use_flush);
        issue_pkg::issue_type_t cls;
        isa_pkg::except_code_t  code;
        isa_pkg::xlen_t         res;
        int                     n;
        ins_seed = lcg_next(ins_seed);
        ref_decode(w, fe, fcode, ins_seed, cls, code, res);
        iq_valid_i = 1'b1;
        iq_instr_i = w;
        iq_except_raised_i = fe;
        iq_except_code_i   = fcode;
        rs1_value_i = ins_seed;
        rs1_ready_i = (cls != issue_pkg::ISSUE_TYPE_CSR);
        n = 0;
        do begin
            @(posedge clk_i);
            n++;
        end while (!iq_ready_o && n < 200);
        if (!iq_ready_o) begin
            proto_errs++;
            $display("instruction %h was not accepted within 200 cycles", w);
        end else if (cls != issue_pkg::ISSUE_TYPE_STALL
                  && cls != issue_pkg::ISSUE_TYPE_WFI) begin
            exp_instr.push_back(w);
            exp_cls.push_back(cls);
            exp_code.push_back(code);
            exp_res.push_back(res);
        end
        #2 iq_valid_i = 1'b0;
        if (cls == issue_pkg::ISSUE_TYPE_CSR || cls == issue_pkg::ISSUE_TYPE_EXCEPT
         || cls == issue_pkg::ISSUE_TYPE_STALL || cls == issue_pkg::ISSUE_TYPE_WFI)
            release_stall(cls, use_flush);
    endtask

    initial begin : time_limit
        #2_000_000;
        $display("simulation time limit reached");
        $display("TB FAILED");
        $finish;
    end

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin : main_seq
        logic [31:0] r;
        table_w[0]  = 32'h00c5_8533;  // add
        table_w[1]  = 32'h00a2_8293;  // addi
        table_w[2]  = 32'h0000_1197;  // auipc
        table_w[3]  = 32'h0042_a383;  // lw
        table_w[4]  = 32'hdead_b2b7;  // lui
        table_w[5]  = 32'h0062_a223;  // sw
        table_w[6]  = 32'h00b5_0463;  // beq
        table_w[7]  = 32'h0080_00ef;  // jal
        table_w[8]  = 32'h0000_80e7;  // jalr
        table_w[9]  = 32'h00b5_7553;  // fp op
        table_w[10] = 32'h0ff0_000f;  // fence
        table_w[11] = 32'h3420_2573;  // csrrs
        table_w[12] = 32'h1050_0073;  // wfi
        table_w[13] = 32'h0000_0073;  // ecall
        table_w[14] = 32'h0010_0073;  // ebreak
        table_w[15] = 32'hffff_ffff;  // reserved opcode
        rst_n_i = 1'b0;
        flush_i = 1'b0;
        iq_valid_i = 1'b0;
        iq_instr_i = '0;
        iq_except_raised_i = 1'b0;
        iq_except_code_i = '0;
        rs1_ready_i = 1'b1;
        rs1_value_i = '0;
        ex_ready_i = 1'b1;
        comm_ready_i = 1'b1;
        comm_resume_i = 1'b0;
        repeat (16) @(posedge clk_i);
        #2 rst_n_i = 1'b1;
        #5;  // control unit still in its reset state
        check_bit("reset iq_ready", 1'b0, iq_ready_o);
        check_bit("reset ex_valid", 1'b0, ex_valid_o);
        check_bit("reset comm_valid", 1'b0, comm_valid_o);
        check_bit("reset regstat valid", 1'b0, int_regstat_valid_o);
        check_bit("reset res ready", 1'b0, comm_res_ready_o);
        check_bit("reset jb instr", 1'b0, comm_jb_instr_o);
        @(posedge clk_i);
        #2;
        check_bit("idle iq_ready", 1'b1, iq_ready_o);

        // each class once with readies held high
        for (int i = 0; i < 16; i++) send_instr(table_w[i], 1'b0, '0, 1'b0);
        send_instr(32'h3020_0073, 1'b0, '0, 1'b0);                 // mret is illegal here
        send_instr(table_w[0], 1'b1, isa_pkg::EXC_INSTR_FAULT, 1'b0);
        send_instr(table_w[10], 1'b0, '0, 1'b1);                   // stall left by flush
        wait_commit_drain();

        // random mix under random readies
        rand_ready = 1'b1;
        repeat (150) begin
            ins_seed = lcg_next(ins_seed);
            r = ins_seed;
            send_instr(table_w[r[19:16]], r[7:0] < 8'd10, 4'd12, r[11] & r[12]);
            if (r[9:8] == 2'b00) begin
                @(posedge clk_i);
                #2;
            end
        end
        rand_ready = 1'b0;
        wait_commit_drain();

        $display("errors: %0d value, %0d protocol", value_errs, proto_errs);
        if (value_errs + proto_errs == 0) $display("TB PASSED");
        else $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/issue_stage.sv */
// Issue stage top level
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  flush_i,

    // issue queue
    input  logic                  iq_valid_i,
    output logic                  iq_ready_o,
    input  isa_pkg::instr_t       iq_instr_i,
    input  logic                  iq_except_raised_i,
    input  isa_pkg::except_code_t iq_except_code_i,

    // operand of the held instruction
    input  logic                  rs1_ready_i,
    input  isa_pkg::xlen_t        rs1_value_i,

    // execution units
    input  logic                  ex_ready_i,
    output logic                  ex_valid_o,
    output isa_pkg::instr_t       ex_instr_o,

    // integer register status
    output logic                  int_regstat_valid_o,
    output isa_pkg::reg_addr_t    int_regstat_rd_o,

    // commit
    input  logic                  comm_ready_i,
    output logic                  comm_valid_o,
    output isa_pkg::instr_t       comm_instr_o,
    output logic                  comm_res_ready_o,
    output isa_pkg::xlen_t        comm_res_value_o,
    output logic                  comm_jb_instr_o,
    output logic                  comm_except_o,
    output isa_pkg::except_code_t comm_except_code_o,
    input  logic                  comm_resume_i
);

    issue_pkg::issue_type_t issue_type;
    isa_pkg::except_code_t  dec_except_code;
    isa_pkg::instr_t        issue_instr;
    logic                   reg_en;
    logic                   res_sel_rs1;
    logic                   fetch_except;

    // --------------------------------------------------
    // decoder, control unit, issue register
    // --------------------------------------------------
    issue_decoder u_issue_decoder (
        .iq_instr_i         (iq_instr_i),
        .iq_except_raised_i (iq_except_raised_i),
        .issue_type_o       (issue_type),
        .dec_except_code_o  (dec_except_code)
    );

    issue_cu u_issue_cu (
        .clk_i                (clk_i),
        .rst_n_i              (rst_n_i),
        .flush_i              (flush_i),
        .iq_valid_i           (iq_valid_i),
        .iq_ready_o           (iq_ready_o),
        .iq_except_raised_i   (iq_except_raised_i),
        .issue_type_i         (issue_type),
        .issue_rs1_ready_i    (rs1_ready_i),
        .issue_reg_en_o       (reg_en),
        .issue_res_ready_o    (comm_res_ready_o),
        .issue_res_sel_rs1_o  (res_sel_rs1),
        .issue_fetch_except_o (fetch_except),
        .ex_ready_i           (ex_ready_i),
        .ex_valid_o           (ex_valid_o),
        .int_regstat_valid_o  (int_regstat_valid_o),
        .comm_ready_i         (comm_ready_i),
        .comm_valid_o         (comm_valid_o),
        .comm_resume_i        (comm_resume_i),
        .comm_jb_instr_o      (comm_jb_instr_o)
    );

    issue_reg u_issue_reg (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),
        .reg_en_i            (reg_en),
        .flush_i             (flush_i),
        .instr_i             (iq_instr_i),
        .issue_type_i        (issue_type),
        .except_raised_i     (iq_except_raised_i),
        .fetch_except_code_i (iq_except_code_i),
        .dec_except_code_i   (dec_except_code),
        .res_sel_rs1_i       (res_sel_rs1),
        .fetch_except_i      (fetch_except),
        .rs1_value_i         (rs1_value_i),
        .instr_o             (issue_instr),
        .rd_o                (int_regstat_rd_o),
        .res_value_o         (comm_res_value_o),
        .except_o            (comm_except_o),
        .except_code_o       (comm_except_code_o)
    );

    // the same held word goes to both sides
    assign ex_instr_o   = issue_instr;
    assign comm_instr_o = issue_instr;

endmodule

`default_nettype wire

/* verilog/issue_reg.sv */
// Issue register
`timescale 1ns/1ps
`default_nettype none

module issue_reg (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   reg_en_i,
    input  logic                   flush_i,
    input  isa_pkg::instr_t        instr_i,
    input  issue_pkg::issue_type_t issue_type_i,
    input  logic                   except_raised_i,     // fetch exception
    input  isa_pkg::except_code_t  fetch_except_code_i,
    input  isa_pkg::except_code_t  dec_except_code_i,
    input  logic                   res_sel_rs1_i,
    input  logic                   fetch_except_i,
    input  isa_pkg::xlen_t         rs1_value_i,
    output isa_pkg::instr_t        instr_o,
    output isa_pkg::reg_addr_t     rd_o,
    output isa_pkg::xlen_t         res_value_o,
    output logic                   except_o,
    output isa_pkg::except_code_t  except_code_o
);

    isa_pkg::instr_t       instr_q;
    isa_pkg::xlen_t        imm_q;    // U-type immediate
    isa_pkg::reg_addr_t    rd_q;
    isa_pkg::except_code_t code_q;
    logic                  except_q;

    // payload
    always_ff @(posedge clk_i) begin : reg_payload
        if (reg_en_i) begin
            instr_q <= instr_i;
            imm_q   <= {instr_i[31:12], 12'h000};
            rd_q    <= instr_i[11:7];
            code_q  <= except_raised_i ? fetch_except_code_i : dec_except_code_i;
        end
    end

    // exception flag
    always_ff @(posedge clk_i or negedge rst_n_i) begin : reg_except
        if (!rst_n_i) begin
            except_q <= 1'b0;
        end else if (flush_i) begin
            except_q <= 1'b0;
        end else if (reg_en_i) begin
            except_q <= (issue_type_i == issue_pkg::ISSUE_TYPE_EXCEPT);
        end
    end

    assign instr_o       = instr_q;
    assign rd_o          = rd_q;
    assign res_value_o   = res_sel_rs1_i ? rs1_value_i : imm_q;
    assign except_o      = fetch_except_i | except_q;
    assign except_code_o = code_q;

endmodule

`default_nettype wire

/* verilog/issue_cu.sv */
// Issue control unit
`timescale 1ns/1ps
`default_nettype none

module issue_cu (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   flush_i,

    // issue queue
    input  logic                   iq_valid_i,
    output logic                   iq_ready_o,
    input  logic                   iq_except_raised_i,

    // issue register and decoder
    input  issue_pkg::issue_type_t issue_type_i,
    input  logic                   issue_rs1_ready_i,  // CSR operand available
    output logic                   issue_reg_en_o,
    output logic                   issue_res_ready_o,
    output logic                   issue_res_sel_rs1_o,
    output logic                   issue_fetch_except_o,

    // execution units and register status
    input  logic                   ex_ready_i,
    output logic                   ex_valid_o,
    output logic                   int_regstat_valid_o,

    // commit
    input  logic                   comm_ready_i,
    output logic                   comm_valid_o,
    input  logic                   comm_resume_i,
    output logic                   comm_jb_instr_o
);

    issue_pkg::cu_state_t curr_state, v_next_state, next_state;
    logic                 downstream_ready;  // execution and commit both ready
    logic                 ex_transfer;       // class goes to execution too
    logic                 commit_only;

    assign downstream_ready = ex_ready_i & comm_ready_i;

    // --------------------------------------------------
    // state reached by a valid instruction
    // --------------------------------------------------
    always_comb begin : cu_valid_next
        if (iq_except_raised_i) begin
            v_next_state = issue_pkg::S_FETCH_EXCEPT;
        end else begin
            case (issue_type_i)
                issue_pkg::ISSUE_TYPE_NONE:   v_next_state = issue_pkg::S_ISSUE_NONE;
                issue_pkg::ISSUE_TYPE_INT:    v_next_state = issue_pkg::S_ISSUE_INT;
                issue_pkg::ISSUE_TYPE_LUI:    v_next_state = issue_pkg::S_ISSUE_LUI;
                issue_pkg::ISSUE_TYPE_STORE:  v_next_state = issue_pkg::S_ISSUE_STORE;
                issue_pkg::ISSUE_TYPE_BRANCH: v_next_state = issue_pkg::S_ISSUE_BRANCH;
                issue_pkg::ISSUE_TYPE_JUMP:   v_next_state = issue_pkg::S_ISSUE_JUMP;
                issue_pkg::ISSUE_TYPE_FP:     v_next_state = issue_pkg::S_ISSUE_FP;
                issue_pkg::ISSUE_TYPE_CSR:    v_next_state = issue_pkg::S_CSR_WAIT_OP;
                issue_pkg::ISSUE_TYPE_STALL,
                issue_pkg::ISSUE_TYPE_WFI:    v_next_state = issue_pkg::S_STALL;
                default:                      v_next_state = issue_pkg::S_ISSUE_EXCEPT;
            endcase
        end
    end

    // --------------------------------------------------
    // state progression
    // --------------------------------------------------
    always_comb begin : cu_state_prog
        next_state = curr_state; // hold by default
        case (curr_state)
            issue_pkg::S_RESET: next_state = issue_pkg::S_IDLE;
            issue_pkg::S_IDLE: begin
                if (iq_valid_i) next_state = v_next_state;
            end
            issue_pkg::S_ISSUE_NONE,
            issue_pkg::S_ISSUE_LUI: begin
                if (comm_ready_i) begin
                    next_state = iq_valid_i ? v_next_state : issue_pkg::S_IDLE;
                end
            end
            issue_pkg::S_ISSUE_INT,
            issue_pkg::S_ISSUE_STORE,
            issue_pkg::S_ISSUE_BRANCH,
            issue_pkg::S_ISSUE_JUMP,
            issue_pkg::S_ISSUE_FP: begin
                if (downstream_ready) begin
                    next_state = iq_valid_i ? v_next_state : issue_pkg::S_IDLE;
                end
            end
            issue_pkg::S_CSR_WAIT_OP: begin
                if (issue_rs1_ready_i) next_state = issue_pkg::S_ISSUE_CSR;
            end
            issue_pkg::S_ISSUE_CSR,
            issue_pkg::S_ISSUE_EXCEPT,
            issue_pkg::S_FETCH_EXCEPT: begin
                if (comm_ready_i) next_state = issue_pkg::S_STALL; // no speculation past these
            end
            issue_pkg::S_STALL: begin
                if (comm_resume_i) next_state = issue_pkg::S_IDLE;
            end
            default: next_state = issue_pkg::S_RESET;
        endcase
    end

    // --------------------------------------------------
    // outputs, Mealy on the ready inputs
    // --------------------------------------------------
    assign ex_transfer = (curr_state == issue_pkg::S_ISSUE_INT)
                       || (curr_state == issue_pkg::S_ISSUE_STORE)
                       || (curr_state == issue_pkg::S_ISSUE_BRANCH)
                       || (curr_state == issue_pkg::S_ISSUE_JUMP)
                       || (curr_state == issue_pkg::S_ISSUE_FP);
    assign commit_only = (curr_state == issue_pkg::S_ISSUE_NONE)
                       || (curr_state == issue_pkg::S_ISSUE_LUI);

    always_comb begin : cu_out_eval
        iq_ready_o           = 1'b0;
        issue_reg_en_o       = 1'b0;
        issue_res_ready_o    = 1'b0;
        issue_res_sel_rs1_o  = 1'b0;
        issue_fetch_except_o = 1'b0;
        ex_valid_o           = 1'b0;
        int_regstat_valid_o  = 1'b0;
        comm_valid_o         = 1'b0;
        comm_jb_instr_o      = 1'b0;

        if (curr_state == issue_pkg::S_IDLE) begin
            iq_ready_o     = 1'b1;
            issue_reg_en_o = 1'b1;
        end else if (ex_transfer) begin
            ex_valid_o          = downstream_ready;
            comm_valid_o        = downstream_ready;
            iq_ready_o          = downstream_ready;
            issue_reg_en_o      = downstream_ready;
            comm_jb_instr_o     = (curr_state == issue_pkg::S_ISSUE_BRANCH)
                                || (curr_state == issue_pkg::S_ISSUE_JUMP);
            int_regstat_valid_o = downstream_ready
                                & ((curr_state == issue_pkg::S_ISSUE_INT)
                                || (curr_state == issue_pkg::S_ISSUE_JUMP));
        end else if (commit_only) begin
            comm_valid_o        = 1'b1;
            issue_res_ready_o   = 1'b1;  // result is the immediate
            iq_ready_o          = comm_ready_i;
            issue_reg_en_o      = comm_ready_i;
            int_regstat_valid_o = comm_ready_i & (curr_state == issue_pkg::S_ISSUE_LUI);
        end else if (curr_state == issue_pkg::S_ISSUE_CSR) begin
            comm_valid_o        = 1'b1;
            issue_res_ready_o   = 1'b1;
            issue_res_sel_rs1_o = 1'b1;  // csr read returns rs1
            int_regstat_valid_o = comm_ready_i;
        end else if ((curr_state == issue_pkg::S_ISSUE_EXCEPT)
                  || (curr_state == issue_pkg::S_FETCH_EXCEPT)) begin
            comm_valid_o         = 1'b1;
            issue_reg_en_o       = comm_ready_i;
            issue_fetch_except_o = (curr_state == issue_pkg::S_FETCH_EXCEPT);
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin : cu_state_upd
        if (!rst_n_i) begin
            curr_state <= issue_pkg::S_RESET;
        end else if (flush_i) begin
            curr_state <= issue_pkg::S_IDLE;
        end else begin
            curr_state <= next_state;
        end
    end

endmodule

`default_nettype wire

/* verilog/issue_decoder.sv */
// Issue class decoder
`timescale 1ns/1ps
`default_nettype none

module issue_decoder (
    input  isa_pkg::instr_t        iq_instr_i,
    input  logic                   iq_except_raised_i,
    output issue_pkg::issue_type_t issue_type_o,
    output isa_pkg::except_code_t  dec_except_code_o
);

    isa_pkg::opcode_t opcode;
    logic [2:0]       funct3;

    assign opcode = iq_instr_i[6:0];
    assign funct3 = iq_instr_i[14:12];

    // anything not matched below is an illegal instruction
    always_comb begin : dec_class
        issue_type_o      = issue_pkg::ISSUE_TYPE_EXCEPT;
        dec_except_code_o = isa_pkg::EXC_ILLEGAL;
        if (iq_except_raised_i) begin
            dec_except_code_o = isa_pkg::EXC_INSTR_FAULT; // word itself is garbage
        end else begin
            case (opcode)
                isa_pkg::OPCODE_OP,
                isa_pkg::OPCODE_OP_IMM,
                isa_pkg::OPCODE_AUIPC,
                isa_pkg::OPCODE_LOAD:     issue_type_o = issue_pkg::ISSUE_TYPE_INT;
                isa_pkg::OPCODE_LUI:      issue_type_o = issue_pkg::ISSUE_TYPE_LUI;
                isa_pkg::OPCODE_STORE:    issue_type_o = issue_pkg::ISSUE_TYPE_STORE;
                isa_pkg::OPCODE_BRANCH:   issue_type_o = issue_pkg::ISSUE_TYPE_BRANCH;
                isa_pkg::OPCODE_JAL,
                isa_pkg::OPCODE_JALR:     issue_type_o = issue_pkg::ISSUE_TYPE_JUMP;
                isa_pkg::OPCODE_OP_FP:    issue_type_o = issue_pkg::ISSUE_TYPE_FP;
                isa_pkg::OPCODE_MISC_MEM: issue_type_o = issue_pkg::ISSUE_TYPE_STALL;
                isa_pkg::OPCODE_SYSTEM: begin
                    if (funct3 != isa_pkg::FUNCT3_PRIV) begin
                        issue_type_o = issue_pkg::ISSUE_TYPE_CSR;
                    end else if (iq_instr_i == isa_pkg::INSTR_WFI) begin
                        issue_type_o = issue_pkg::ISSUE_TYPE_WFI;
                    end else if (iq_instr_i == isa_pkg::INSTR_ECALL) begin
                        dec_except_code_o = isa_pkg::EXC_ECALL;
                    end else if (iq_instr_i == isa_pkg::INSTR_EBREAK) begin
                        dec_except_code_o = isa_pkg::EXC_BREAKPOINT;
                    end
                end
                default: ; // reserved opcode
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/issue_pkg.sv */
// Issue stage control types
`default_nettype none

package issue_pkg;

    // what the issue stage must do with an instruction
    typedef enum logic [3:0] {
        ISSUE_TYPE_NONE,    // commit only, result ready
        ISSUE_TYPE_INT,
        ISSUE_TYPE_LUI,
        ISSUE_TYPE_STORE,
        ISSUE_TYPE_BRANCH,
        ISSUE_TYPE_JUMP,
        ISSUE_TYPE_FP,
        ISSUE_TYPE_CSR,
        ISSUE_TYPE_STALL,   // fence, wait for commit to drain
        ISSUE_TYPE_WFI,
        ISSUE_TYPE_EXCEPT
    } issue_type_t;

    // issue control unit states
    typedef enum logic [3:0] {
        S_RESET,
        S_IDLE,
        S_ISSUE_NONE,
        S_ISSUE_INT,
        S_ISSUE_LUI,
        S_ISSUE_STORE,
        S_ISSUE_BRANCH,
        S_ISSUE_JUMP,
        S_ISSUE_FP,
        S_CSR_WAIT_OP,      // wait for rs1 of a CSR instruction
        S_ISSUE_CSR,
        S_ISSUE_EXCEPT,
        S_FETCH_EXCEPT,
        S_STALL             // wait for resume from commit
    } cu_state_t;

endpackage

`default_nettype wire

/* verilog/isa_pkg.sv */
// RISC-V ISA definitions
`default_nettype none

package isa_pkg;

    // --------------------------------------------------
    // widths with a meaning
    // --------------------------------------------------
    typedef logic [31:0] instr_t;       // instruction word
    typedef logic [31:0] xlen_t;        // operands and results
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [3:0]  except_code_t; // mcause code

    // --------------------------------------------------
    // major opcodes
    // --------------------------------------------------
    localparam opcode_t OPCODE_LUI      = 7'b0110111;
    localparam opcode_t OPCODE_AUIPC    = 7'b0010111;
    localparam opcode_t OPCODE_JAL      = 7'b1101111;
    localparam opcode_t OPCODE_JALR     = 7'b1100111;
    localparam opcode_t OPCODE_BRANCH   = 7'b1100011;
    localparam opcode_t OPCODE_LOAD     = 7'b0000011;
    localparam opcode_t OPCODE_STORE    = 7'b0100011;
    localparam opcode_t OPCODE_OP_IMM   = 7'b0010011;
    localparam opcode_t OPCODE_OP       = 7'b0110011;
    localparam opcode_t OPCODE_MISC_MEM = 7'b0001111;
    localparam opcode_t OPCODE_SYSTEM   = 7'b1110011;
    localparam opcode_t OPCODE_OP_FP    = 7'b1010011;

    // funct3 of SYSTEM instructions without CSR access
    localparam logic [2:0] FUNCT3_PRIV = 3'b000;

    // full encodings of the privileged SYSTEM instructions
    localparam instr_t INSTR_ECALL  = 32'h0000_0073;
    localparam instr_t INSTR_EBREAK = 32'h0010_0073;
    localparam instr_t INSTR_WFI    = 32'h1050_0073;

    // --------------------------------------------------
    // exception causes
    // --------------------------------------------------
    localparam except_code_t EXC_INSTR_FAULT = 4'd1;
    localparam except_code_t EXC_ILLEGAL     = 4'd2;
    localparam except_code_t EXC_BREAKPOINT  = 4'd3;
    localparam except_code_t EXC_ECALL       = 4'd11; // ecall from M-mode

endpackage

`default_nettype wire
